/* hw/serdes_pkg.sv */
`default_nettype none

package serdes_pkg;

  // ---------------------------------------------------------------------
  // Sizes
  // ---------------------------------------------------------------------

  // Words gathered into one parallel frame.
  localparam int N_SAMPLES = 8;

  // Width of one word on either stream.
  localparam int BIT_WIDTH = 32;

  // Enough bits to index every word of a frame.
  localparam int IDX_WIDTH = $clog2(N_SAMPLES);

  // ---------------------------------------------------------------------
  // State encodings
  // ---------------------------------------------------------------------

  // The deserializer gathers words in DES_FILL and offers the frame in DES_FULL.
  typedef enum logic [0:0] {
    DES_FILL = 1'b0,
    DES_FULL = 1'b1
  } des_state_e;

  // The serializer waits for a frame in SER_IDLE and sends it in SER_DRAIN.
  typedef enum logic [0:0] {
    SER_IDLE  = 1'b0,
    SER_DRAIN = 1'b1
  } ser_state_e;

endpackage

`default_nettype wire

/* hw/sample_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_counter (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             clear,
  input  logic                             step,
  output logic [serdes_pkg::IDX_WIDTH-1:0] idx,
  output logic                             last
);

  import serdes_pkg::*;

  assign last = (idx == IDX_WIDTH'(N_SAMPLES - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      idx <= '0;
    end else if (clear) begin
      idx <= '0;
    end else if (step) begin
      if (last) begin
        idx <= '0;  // Wrap after the final word of a frame.
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/deser_control.sv */
`timescale 1ns/1ps
`default_nettype none

module deser_control (
  input  logic clk,
  input  logic reset,
  input  logic recv_val,
  input  logic frame_rdy,
  output logic recv_rdy,
  output logic frame_val,
  output logic step,
  output logic clear,
  input  logic last
);

  import serdes_pkg::*;

  des_state_e state;
  des_state_e state_next;

  // Handshake outputs depend on the state alone.
  assign recv_rdy  = (state == DES_FILL);
  assign frame_val = (state == DES_FULL);

  assign step  = recv_rdy & recv_val;  // A word is taken this cycle.
  assign clear = frame_val & frame_rdy;

  always_comb begin
    state_next = state;
    case (state)
      DES_FILL: begin
        if (step && last) begin
          state_next = DES_FULL;
        end
      end
      DES_FULL: begin
        if (frame_rdy) begin
          state_next = DES_FILL;
        end
      end
      default: state_next = DES_FILL;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= DES_FILL;
    end else begin
      state <= state_next;
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  // The counter wraps on the final word, so a held frame sees index 0.
  frame_idx_wrapped: assert property (
    @(posedge clk) disable iff (reset)
    frame_val |-> !last
  ) else $error("deser_control: last sample flag high while the frame is offered");

endmodule

`default_nettype wire

/* hw/sample_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_bank (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             wr_en,
  input  logic [serdes_pkg::IDX_WIDTH-1:0] idx,
  input  logic [serdes_pkg::BIT_WIDTH-1:0] wr_msg,
  output logic [serdes_pkg::BIT_WIDTH-1:0] frame_msg [serdes_pkg::N_SAMPLES]
);

  import serdes_pkg::*;

  logic [N_SAMPLES-1:0] wr_sel;

  // One-hot select of the word register to load.
  assign wr_sel = {{(N_SAMPLES - 1){1'b0}}, 1'b1} << idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < N_SAMPLES; i++) begin
        frame_msg[i] <= '0;
      end
    end else if (wr_en) begin
      for (int i = 0; i < N_SAMPLES; i++) begin
        if (wr_sel[i]) begin
          frame_msg[i] <= wr_msg;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/deserializer.sv */
`timescale 1ns/1ps
`default_nettype none

module deserializer (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             recv_val,
  output logic                             recv_rdy,
  input  logic [serdes_pkg::BIT_WIDTH-1:0] recv_msg,
  output logic                             frame_val,
  input  logic                             frame_rdy,
  output logic [serdes_pkg::BIT_WIDTH-1:0] frame_msg [serdes_pkg::N_SAMPLES]
);

  import serdes_pkg::*;

  logic                 step;
  logic                 clear;
  logic                 last;
  logic [IDX_WIDTH-1:0] idx;

  deser_control ctrl0 (
    .clk       (clk),
    .reset     (reset),
    .recv_val  (recv_val),
    .frame_rdy (frame_rdy),
    .recv_rdy  (recv_rdy),
    .frame_val (frame_val),
    .step      (step),
    .clear     (clear),
    .last      (last)
  );

  sample_counter cnt0 (
    .clk   (clk),
    .reset (reset),
    .clear (clear),
    .step  (step),
    .idx   (idx),
    .last  (last)
  );

  // Word k of a frame lands in entry k.
  sample_bank bank0 (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (step),
    .idx       (idx),
    .wr_msg    (recv_msg),
    .frame_msg (frame_msg)
  );

endmodule

`default_nettype wire

/* hw/serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module serializer (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             frame_val,
  output logic                             frame_rdy,
  input  logic [serdes_pkg::BIT_WIDTH-1:0] frame_msg [serdes_pkg::N_SAMPLES],
  output logic                             send_val,
  input  logic                             send_rdy,
  output logic [serdes_pkg::BIT_WIDTH-1:0] send_msg
);

  import serdes_pkg::*;

  ser_state_e state;
  ser_state_e state_next;

  logic [BIT_WIDTH-1:0] frame_reg [N_SAMPLES];
  logic                 load;
  logic                 step;
  logic                 last;
  logic [IDX_WIDTH-1:0] idx;

  // ---------------------------------------------------------------------
  // Handshakes
  // ---------------------------------------------------------------------

  assign frame_rdy = (state == SER_IDLE);
  assign send_val  = (state == SER_DRAIN);

  assign load = frame_val & frame_rdy;  // Frame handed over this cycle.
  assign step = send_val & send_rdy;

  // ---------------------------------------------------------------------
  // Frame copy and word select
  // ---------------------------------------------------------------------

  // A private copy frees the deserializer to gather the next frame.
  always_ff @(posedge clk) begin
    if (load) begin
      frame_reg <= frame_msg;
    end
  end

  assign send_msg = frame_reg[idx];

  sample_counter cnt0 (
    .clk   (clk),
    .reset (reset),
    .clear (load),
    .step  (step),
    .idx   (idx),
    .last  (last)
  );

  // ---------------------------------------------------------------------
  // Drain FSM
  // ---------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      SER_IDLE: begin
        if (frame_val) begin
          state_next = SER_DRAIN;
        end
      end
      SER_DRAIN: begin
        if (step && last) begin
          state_next = SER_IDLE;  // Final word has left.
        end
      end
      default: state_next = SER_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SER_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // The output word must not move under a stalled receiver.
  send_held: assert property (
    @(posedge clk) disable iff (reset)
    send_val && !send_rdy |=> send_val && $stable(send_msg)
  ) else $error("serializer: send_msg changed while send_rdy was low");

endmodule

`default_nettype wire

/* hw/serdes_top.sv */
`timescale 1ns/1ps
`default_nettype none

module serdes_top (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             recv_val,
  output logic                             recv_rdy,
  input  logic [serdes_pkg::BIT_WIDTH-1:0] recv_msg,
  output logic                             send_val,
  input  logic                             send_rdy,
  output logic [serdes_pkg::BIT_WIDTH-1:0] send_msg
);

  import serdes_pkg::*;

  // Parallel frame between the two halves.
  logic                 frame_val;
  logic                 frame_rdy;
  logic [BIT_WIDTH-1:0] frame_msg [N_SAMPLES];

  deserializer des0 (
    .clk       (clk),
    .reset     (reset),
    .recv_val  (recv_val),
    .recv_rdy  (recv_rdy),
    .recv_msg  (recv_msg),
    .frame_val (frame_val),
    .frame_rdy (frame_rdy),
    .frame_msg (frame_msg)
  );

  // Words leave in the order they arrived.
  serializer ser0 (
    .clk       (clk),
    .reset     (reset),
    .frame_val (frame_val),
    .frame_rdy (frame_rdy),
    .frame_msg (frame_msg),
    .send_val  (send_val),
    .send_rdy  (send_rdy),
    .send_msg  (send_msg)
  );

endmodule

`default_nettype wire

/* test/serdes_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module serdes_tb;

  import serdes_pkg::*;

  logic                 clk;
  logic                 reset;
  logic                 recv_val;
  logic                 recv_rdy;
  logic [BIT_WIDTH-1:0] recv_msg;
  logic                 send_val;
  logic                 send_rdy;
  logic [BIT_WIDTH-1:0] send_msg;

  // Reference queue of words accepted but not yet sent.
  logic [BIT_WIDTH-1:0] ref_q [$];

  int errors = 0;
  int in_count = 0;   // Words accepted since reset.
  int out_total = 0;  // Words sent since reset.
  int ready_mode = 0;

  // Values observed at the falling edge, checked at the next rising edge.
  logic                 in_xfer = 1'b0;
  logic                 out_xfer = 1'b0;
  logic                 exp_ok = 1'b0;
  logic [BIT_WIDTH-1:0] exp_msg = '0;
  logic [BIT_WIDTH-1:0] obs_msg = '0;
  logic [BIT_WIDTH-1:0] prev_msg = '0;
  logic                 obs_val = 1'b0;
  logic                 obs_rdy = 1'b0;
  logic                 stall_now = 1'b0;
  logic                 stall_prev = 1'b0;
  logic                 reset_prev = 1'b0;
  logic                 reset_applied = 1'b0;
  logic                 frame_waiting = 1'b0;
  logic                 fill_start = 1'b0;
  logic                 fill_d1 = 1'b0;
  logic                 fill_d2 = 1'b0;

  serdes_top dut0 (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .recv_msg (recv_msg),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .send_msg (send_msg)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------------------------
  // Reference model, updated half a cycle before each rising edge
  // --------------------------------------------------------------------

  always @(negedge clk) begin
    reset_applied = reset_prev;  // Reset as seen by the last rising edge.
    reset_prev    = reset;
    // More than a frame in flight on a frame boundary means the deserializer is full.
    frame_waiting = (ref_q.size() > N_SAMPLES) && (in_count % N_SAMPLES == 0);
    obs_val       = send_val;
    obs_rdy       = recv_rdy;
    prev_msg      = obs_msg;
    obs_msg       = send_msg;
    stall_prev    = stall_now;
    stall_now     = !reset && send_val && !send_rdy;
    in_xfer       = !reset && recv_val && recv_rdy;
    out_xfer      = !reset && send_val && send_rdy;
    fill_d2       = fill_d1;
    fill_d1       = fill_start;
    fill_start    = in_xfer && (in_count % N_SAMPLES == N_SAMPLES - 1) && !send_val;
    if (out_xfer) begin
      if (ref_q.size() > 0) begin
        exp_ok  = 1'b1;
        exp_msg = ref_q.pop_front();
        out_total++;
      end else begin
        exp_ok  = 1'b0;
        exp_msg = '0;
      end
    end
    if (in_xfer) begin
      ref_q.push_back(recv_msg);
      in_count++;
    end
  end

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------

  reset_send_val: assert property (@(posedge clk) reset_applied |-> !obs_val)
    else begin
      errors++;
      $display("ERROR at %0t ns: send_val = %b, expected 0", $time, obs_val);
    end

  reset_recv_rdy: assert property (@(posedge clk) reset_applied |-> obs_rdy)
    else begin
      errors++;
      $display("ERROR at %0t ns: recv_rdy = %b, expected 1", $time, obs_rdy);
    end

  out_has_ref: assert property (@(posedge clk) disable iff (reset) out_xfer |-> exp_ok)
    else begin
      errors++;
      $display("At %0t ns a word was sent although no input word was waiting.", $time);
    end

  out_order: assert property (
    @(posedge clk) disable iff (reset) out_xfer && exp_ok |-> obs_msg == exp_msg
  ) else begin
    errors++;
    $display("ERROR at %0t ns: send_msg = 0x%08h, expected 0x%08h", $time, obs_msg, exp_msg);
  end

  // Two cycles from the last accepted word to the first output word.
  fill_quiet: assert property (@(posedge clk) disable iff (reset) fill_d1 |-> !obs_val)
    else begin
      errors++;
      $display("ERROR at %0t ns: send_val = %b, expected 0 one cycle after fill", $time, obs_val);
    end

  fill_rise: assert property (@(posedge clk) disable iff (reset) fill_d2 |-> obs_val)
    else begin
      errors++;
      $display("ERROR at %0t ns: send_val = %b, expected 1 two cycles after fill", $time, obs_val);
    end

  stall_val: assert property (@(posedge clk) disable iff (reset) stall_prev |-> obs_val)
    else begin
      errors++;
      $display("ERROR at %0t ns: send_val = %b, expected 1 during a stall", $time, obs_val);
    end

  stall_msg: assert property (
    @(posedge clk) disable iff (reset) stall_prev |-> obs_msg == prev_msg
  ) else begin
    errors++;
    $display("ERROR at %0t ns: send_msg = 0x%08h, expected 0x%08h", $time, obs_msg, prev_msg);
  end

  two_frames: assert property (
    @(posedge clk) disable iff (reset) frame_waiting |-> !obs_rdy
  ) else begin
    errors++;
    $display("At %0t ns recv_rdy stayed high after a second frame was gathered.", $time);
  end

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------

  // Mode 0 keeps send_rdy high, 1 is random, 2 stalls for 30 of every 40 cycles.
  initial begin : ready_driver
    int cycle;
    cycle = 0;
    send_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      cycle++;
      case (ready_mode)
        0: send_rdy = 1'b1;
        1: send_rdy = ($urandom % 2) == 0;
        default: send_rdy = (cycle % 40) >= 30;
      endcase
    end
  end

  // Offers n_words random words, holding each one until it is taken.
  task automatic drive_input(input int n_words, input int idle_pct);
    int accepted;
    accepted = 0;
    while (accepted < n_words) begin
      @(posedge clk);
      #1;
      if (in_xfer) begin
        accepted++;
        recv_val = 1'b0;
      end
      if (accepted < n_words && !recv_val && int'($urandom % 100) >= idle_pct) begin
        recv_val = 1'b1;
        recv_msg = $urandom;
      end
    end
    recv_val = 1'b0;
  endtask

  task automatic wait_drained(input int target);
    while (ref_q.size() != target) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
  endtask

  initial begin : main
    void'($urandom(32'h0cf5_a0f7));
    reset    = 1'b1;
    recv_val = 1'b0;
    recv_msg = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    // Continuous flow in both directions.
    ready_mode = 0;
    drive_input(6 * N_SAMPLES, 0);
    wait_drained(0);

    // Single frames into an idle serializer.
    repeat (3) begin
      drive_input(N_SAMPLES, 0);
      wait_drained(0);
    end

    // Long stalls on the output side.
    ready_mode = 2;
    drive_input(4 * N_SAMPLES, 0);
    ready_mode = 0;
    wait_drained(0);

    // Random gaps, ending in the middle of a frame.
    ready_mode = 1;
    drive_input(5 * N_SAMPLES + 3, 40);
    ready_mode = 0;
    wait_drained(in_count % N_SAMPLES);
    repeat (4 * N_SAMPLES) @(posedge clk);

    assert (ref_q.size() == in_count % N_SAMPLES)
      else begin
        errors++;
        $display("%0d words are still held, expected %0d from the partial frame.",
                 ref_q.size(), in_count % N_SAMPLES);
      end
    assert (out_total % N_SAMPLES == 0)
      else begin
        errors++;
        $display("%0d words came out, which is not a whole number of frames.", out_total);
      end

    $display("Run complete: %0d words in, %0d words out, %0d errors",
             in_count, out_total, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Budget of 4x a frame's two-way trip per frame, 19 frames in all.
  initial begin : watchdog
    int limit;
    limit = 19 * (2 * N_SAMPLES + 4) * 4 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, the words stopped moving through the DUT.", limit);
    $display("Run aborted: %0d words in, %0d words out, %0d errors",
             in_count, out_total, errors);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* serdes_top.f */
hw/serdes_pkg.sv
hw/sample_counter.sv
hw/deser_control.sv
hw/sample_bank.sv
hw/deserializer.sv
hw/serializer.sv
hw/serdes_top.sv
test/serdes_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the serdes testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/1ps \
  --top-module serdes_tb \
  --Mdir obj_dir \
  -o serdes_sim \
  -f serdes_top.f

./obj_dir/serdes_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
